// File: compile.f
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_way_ram.sv
hdl/dcache_lookup.sv
hdl/dcache_miss_ctrl.sv
hdl/dcache_victim.sv
hdl/dcache_top.sv
verification/tb_clock_gen.sv
verification/mem_model.sv
verification/dcache_tb.sv

// File: verification/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int RANDOM_OPS = 300;
    localparam int MISS_CYCLES = 40;
    // any request may miss, the reload pass included
    localparam int MAX_REQS = 60 + 2 * RANDOM_OPS;
    localparam int TIMEOUT_CYCLES = `DC_SETS + MAX_REQS * MISS_CYCLES + 2000;

    logic  clk, rst;
    logic  req, wr;
    addr_t addr;
    strb_t wstrb;
    word_t wdata;
    logic  addr_ok, data_ok;
    word_t rdata;
    logic  ar_valid, ar_ready, r_valid, r_last;
    addr_t ar_addr, aw_addr;
    word_t r_data, w_data;
    logic  aw_valid, aw_ready, w_valid, w_last, w_ready, b_valid;

    word_t ref_mem [int unsigned];
    logic  exp_load [$];
    word_t exp_data [$];
    addr_t exp_addr [$];
    int    checks = 0;
    int    errors = 0;
    int    cycles = 0;

    tb_clock_gen u_clk (.clk, .rst);

    mem_model u_mem (
        .clk, .ar_valid, .ar_addr, .ar_ready, .r_valid, .r_last, .r_data,
        .aw_valid, .aw_addr, .aw_ready, .w_valid, .w_last, .w_data, .w_ready, .b_valid
    );

    dcache_top u_dut (
        .clk, .rst, .req, .wr, .addr, .wstrb, .wdata, .addr_ok, .data_ok, .rdata,
        .ar_valid, .ar_addr, .ar_ready, .r_valid, .r_last, .r_data,
        .aw_valid, .aw_addr, .aw_ready, .w_valid, .w_last, .w_data, .w_ready, .b_valid
    );

    function automatic word_t ref_word(addr_t a);
        if (ref_mem.exists(a[31:2])) begin
            return ref_mem[a[31:2]];
        end
        return u_mem.init_word(a[31:2]);
    endfunction

    task automatic compare_word(string what, addr_t a, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t ns: %s at %h gave %h, expected %h", $time, what, a, got, exp);
        end
    endtask

    task automatic expect_true(logic cond, string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("ERROR at %0t ns: %s", $time, what);
        end
    endtask

    ////////////////////////////////////////////////
    // request driver and in-order scoreboard
    ////////////////////////////////////////////////

    // called just after a rising edge, returns just after the accepting edge
    task automatic issue_req(logic is_wr, addr_t a, strb_t s, word_t d);
        word_t cur;
        cur = ref_word(a);
        if (is_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    cur[b*8 +: 8] = d[b*8 +: 8];
                end
            end
            ref_mem[a[31:2]] = cur;
        end
        exp_load.push_back(!is_wr);
        exp_data.push_back(cur);
        exp_addr.push_back(a);
        req = 1'b1;
        wr = is_wr;
        addr = a;
        wstrb = s;
        wdata = d;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic drain_reqs();
        if (exp_load.size() != 0) begin
            while (exp_load.size() != 0) @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin
        if (rst && data_ok) begin
            checks++;
            assert (exp_load.size() != 0) else begin
                errors++;
                $display("data_ok pulsed at %0t ns with no request outstanding", $time);
            end
            if (exp_load.size() != 0) begin
                if (exp_load[0]) begin
                    compare_word("load", exp_addr[0], rdata, exp_data[0]);
                end
                void'(exp_load.pop_front());
                void'(exp_data.pop_front());
                void'(exp_addr.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("%0d checks, %0d errors", checks, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////

    task automatic check_reset_sweep();
        int low_cycles;
        low_cycles = 0;
        @(negedge clk);
        expect_true(!data_ok && !ar_valid && !aw_valid && !w_valid, "outputs not low in reset");
        while (!rst) @(negedge clk);
        while (!addr_ok) begin
            expect_true(!data_ok, "data_ok high during the sweep");
            low_cycles++;
            @(negedge clk);
        end
        expect_true(low_cycles >= `DC_SETS, $sformatf("addr_ok low only %0d cycles", low_cycles));
        @(posedge clk);
        #1;
        issue_req(1'b0, 32'h0000_0100, '0, '0);
        drain_reqs();
    endtask

    task automatic load_miss_burst();
        int rd0;
        rd0 = u_mem.rd_bursts;
        issue_req(1'b0, 32'h0001_2354, '0, '0);
        drain_reqs();
        expect_true(u_mem.rd_bursts == rd0 + 1, "load miss did not give one read burst");
        expect_true(u_mem.last_ar_addr == 32'h0001_2354,
                    $sformatf("ar_addr was %h", u_mem.last_ar_addr));
        issue_req(1'b0, 32'h0001_2348, '0, '0);
        drain_reqs();
        expect_true(u_mem.rd_bursts == rd0 + 1, "load in a filled line started a burst");
    endtask

    task automatic store_forwarding();
        strb_t strbs [6] = '{4'b0001, 4'b0110, 4'b1000, 4'b1111, 4'b0101, 4'b1010};
        addr_t a;
        for (int i = 0; i < 6; i++) begin
            a = 32'h0003_0040 + addr_t'((i % 2) * 4);
            issue_req(1'b1, a, strbs[i], 32'h1357_9bdf ^ word_t'(i * 32'h0101_0101));
            issue_req(1'b0, a, '0, '0);
        end
        drain_reqs();
    endtask

    // six tags in one set of four ways
    task automatic set_conflicts();
        int    wr0;
        addr_t a;
        addr_t line_base;
        wr0 = u_mem.wr_bursts;
        for (int t = 1; t <= 6; t++) begin
            a = (addr_t'(t) << 12) | (addr_t'(7'h15) << 5);
            issue_req(1'b1, a, 4'b1111, 32'h5e70_0000 | word_t'(t));
            issue_req(1'b1, a + 12, 4'b0011, 32'h0000_a5a0 + word_t'(t));
        end
        for (int t = 1; t <= 6; t++) begin
            a = (addr_t'(t) << 12) | (addr_t'(7'h15) << 5);
            issue_req(1'b0, a, '0, '0);
            issue_req(1'b0, a + 12, '0, '0);
            issue_req(1'b0, a + 24, '0, '0);
        end
        drain_reqs();
        expect_true(u_mem.wr_bursts > wr0, "no write-back for evicted dirty lines");
        for (int i = wr0; i < u_mem.wr_bursts; i++) begin
            line_base = u_mem.wb_addr[i];
            expect_true(line_base[4:0] == 5'd0, $sformatf("aw_addr %h not line aligned", line_base));
            for (int k = 0; k < `DC_WORDS; k++) begin
                compare_word("write-back", line_base + addr_t'(4 * k),
                             u_mem.wb_data[i * `DC_WORDS + k], ref_word(line_base + addr_t'(4 * k)));
            end
        end
    endtask

    task automatic random_traffic();
        logic  touched [int unsigned];
        int    wr0;
        addr_t a;
        logic  is_wr;
        wr0 = u_mem.wr_bursts;
        repeat (RANDOM_OPS) begin
            a = 32'h4000_0000 | (addr_t'($urandom % 6) << 12) | (addr_t'($urandom % 3) << 5)
                | (addr_t'($urandom % 8) << 2);
            is_wr = $urandom % 2;
            touched[a] = 1'b1;
            issue_req(is_wr, a, strb_t'($urandom), word_t'($urandom));
        end
        // final pass over everything touched
        foreach (touched[k]) begin
            issue_req(1'b0, addr_t'(k), '0, '0);
        end
        drain_reqs();
        expect_true(u_mem.wr_bursts > wr0, "random traffic caused no write-back");
    endtask

    initial begin
        void'($urandom(31216));
        req = 1'b0;
        wr = 1'b0;
        addr = '0;
        wstrb = '0;
        wdata = '0;
        check_reset_sweep();
        load_miss_burst();
        store_forwarding();
        set_conflicts();
        random_traffic();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verification/mem_model.sv
`timescale 1ns/1ps

module mem_model import dcache_pkg::*; (
    input  logic  clk,
    input  logic  ar_valid,
    input  addr_t ar_addr,
    output logic  ar_ready,
    output logic  r_valid,
    output logic  r_last,
    output word_t r_data,
    input  logic  aw_valid,
    input  addr_t aw_addr,
    output logic  aw_ready,
    input  logic  w_valid,
    input  logic  w_last,
    input  word_t w_data,
    output logic  w_ready,
    output logic  b_valid
);

    // keyed by word address
    word_t       mem [int unsigned];
    int          rd_bursts;
    int          wr_bursts;
    addr_t       last_ar_addr;
    addr_t       wb_addr [$];
    word_t       wb_data [$];
    logic        rd_active;
    logic        wr_active;
    logic [29:0] rd_word;
    logic [26:0] wr_line;
    logic [2:0]  rd_cnt;
    logic [2:0]  wr_cnt;
    logic [2:0]  beat_sel;

    function automatic word_t init_word(logic [29:0] waddr);
        return (word_t'(waddr) * 32'h9e37_79b1) ^ 32'h0f0f_5a5a;
    endfunction

    function automatic word_t read_word(logic [29:0] waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return init_word(waddr);
    endfunction

    initial begin
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_last = 1'b0;
        r_data = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        rd_bursts = 0;
        wr_bursts = 0;
        rd_active = 1'b0;
        wr_active = 1'b0;
        rd_cnt = '0;
        wr_cnt = '0;
    end

    // handshakes seen at the falling edge take effect at the next rising edge
    always begin : serve
        logic  ar_fire;
        logic  r_fire;
        logic  aw_fire;
        logic  w_fire;
        logic  w_end;
        word_t w_beat;
        @(negedge clk);
        ar_fire = ar_valid && ar_ready;
        r_fire = r_valid;
        aw_fire = aw_valid && aw_ready;
        w_fire = w_valid && w_ready;
        w_end = w_last;
        w_beat = w_data;
        @(posedge clk);
        #1;
        b_valid = 1'b0;
        if (ar_fire) begin
            rd_active = 1'b1;
            rd_word = ar_addr[31:2];
            rd_cnt = '0;
            rd_bursts++;
            last_ar_addr = ar_addr;
        end else if (r_fire) begin
            rd_cnt++;
            if (rd_cnt == 3'd0) begin
                rd_active = 1'b0;
            end
        end
        if (aw_fire) begin
            wr_active = 1'b1;
            wr_line = aw_addr[31:5];
            wr_cnt = '0;
            wb_addr.push_back(aw_addr);
        end
        if (w_fire) begin
            mem[{wr_line, wr_cnt}] = w_beat;
            wb_data.push_back(w_beat);
            wr_cnt++;
            if (w_end) begin
                wr_active = 1'b0;
                wr_bursts++;
                b_valid = 1'b1;
            end
        end
        // one wait cycle on each address, write beats every other cycle
        ar_ready = ar_valid && !ar_ready && !rd_active;
        aw_ready = aw_valid && !aw_ready && !wr_active;
        w_ready = wr_active && !w_ready;
        beat_sel = rd_word[2:0] + rd_cnt;
        r_valid = rd_active;
        r_last = rd_active && rd_cnt == 3'd7;
        r_data = read_word({rd_word[29:3], beat_sel});
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // held for 4 rising edges, released just after the edge
    initial begin
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
    end

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  logic  wr,
    input  addr_t addr,
    input  strb_t wstrb,
    input  word_t wdata,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata,
    output logic  ar_valid,
    output addr_t ar_addr,
    input  logic  ar_ready,
    input  logic  r_valid,
    input  logic  r_last,
    input  word_t r_data,
    output logic  aw_valid,
    output addr_t aw_addr,
    input  logic  aw_ready,
    output logic  w_valid,
    output logic  w_last,
    output word_t w_data,
    input  logic  w_ready,
    input  logic  b_valid
);

    tag_t      way_tag [`DC_WAYS];
    logic      way_valid [`DC_WAYS];
    line_t     way_line [`DC_WAYS];
    line_be_t  store_be [`DC_WAYS];
    line_be_t  refill_be [`DC_WAYS];
    line_t     s2_lines [`DC_WAYS];
    tag_t      s2_tags [`DC_WAYS];
    index_t    rindex, windex, s2_index;
    tag_t      s2_tag;
    word_sel_t s2_word;
    line_t     store_line, refill_line, line_wdata;
    way_t      tag_we, hit_store_way, victim_way;
    logic      run, recover, s2_miss, valid_wdata, victim_capture, victim_idle;

    // valid_wdata only rises in FINISH
    assign line_wdata = valid_wdata ? refill_line : store_line;

    dcache_lookup u_lookup (
        .clk, .rst, .req, .wr, .addr, .wstrb, .wdata, .addr_ok, .data_ok, .rdata,
        .run, .recover, .way_tag, .way_valid, .way_line, .rindex,
        .data_be(store_be), .line_wdata(store_line), .s2_miss, .s2_index, .s2_tag,
        .s2_word, .s2_lines, .s2_tags, .hit_store_way
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk, .rst, .s2_miss, .s2_index, .s2_tag, .s2_word, .hit_store_way,
        .victim_idle, .run, .recover, .windex, .tag_we, .valid_wdata, .refill_be,
        .refill_line, .victim_capture, .victim_way, .ar_valid, .ar_addr, .ar_ready,
        .r_valid, .r_last, .r_data
    );

    dcache_victim u_victim (
        .clk, .rst, .victim_capture, .victim_way, .s2_index, .s2_tags, .s2_lines,
        .victim_idle, .aw_valid, .aw_addr, .aw_ready, .w_valid, .w_last, .w_data,
        .w_ready, .b_valid
    );

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_way_ram u_ram (
            .clk,
            .rindex,
            .windex,
            .tag_we(tag_we[w]),
            .valid_wdata,
            .tag_wdata(s2_tag),
            .data_be(store_be[w] | refill_be[w]),
            .line_wdata,
            .tag(way_tag[w]),
            .valid(way_valid[w]),
            .line(way_line[w])
        );
    end

endmodule

// File: hdl/dcache_victim.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_victim import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   victim_capture,
    input  way_t   victim_way,
    input  index_t s2_index,
    input  tag_t   s2_tags [`DC_WAYS],
    input  line_t  s2_lines [`DC_WAYS],
    output logic   victim_idle,
    output logic   aw_valid,
    output addr_t  aw_addr,
    input  logic   aw_ready,
    output logic   w_valid,
    output logic   w_last,
    output word_t  w_data,
    input  logic   w_ready,
    input  logic   b_valid
);

    victim_state_e state;
    way_t          cap_way;
    word_t         vbuf [`DC_WORDS];
    word_sel_t     cnt;
    // beats accepted since the address phase
    logic [3:0]    beats;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= V_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                V_IDLE: if (victim_capture) state <= V_CAPTURE;
                V_CAPTURE: state <= V_ADDR;
                V_ADDR: begin
                    if (aw_ready) begin
                        state <= V_DATA;
                        cnt <= '0;
                    end
                end
                V_DATA: begin
                    if (w_ready) begin
                        cnt <= cnt + 1'b1;
                        if (w_last) begin
                            state <= V_RESP;
                        end
                    end
                end
                V_RESP: if (b_valid) state <= V_IDLE;
                default: state <= V_IDLE;
            endcase
        end
    end

    // set is still on the array outputs while the miss is pending
    always_ff @(posedge clk) begin
        if (state == V_IDLE && victim_capture) begin
            cap_way <= victim_way;
        end
        if (state == V_CAPTURE) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (cap_way[w]) begin
                    aw_addr <= {s2_tags[w], s2_index, 5'b00000};
                    for (int k = 0; k < `DC_WORDS; k++) begin
                        vbuf[k] <= s2_lines[w][k*32 +: 32];
                    end
                end
            end
        end
    end

    assign victim_idle = state == V_IDLE;
    assign aw_valid = state == V_ADDR;
    assign w_valid = state == V_DATA;
    assign w_last = w_valid && cnt == `DC_WORDS - 1;
    assign w_data = vbuf[cnt];

    always_ff @(posedge clk) begin
        if (!rst) begin
            beats <= '0;
        end else if (aw_valid && aw_ready) begin
            beats <= '0;
        end else if (w_valid && w_ready) begin
            beats <= beats + 1'b1;
        end
    end

    a_last_beat: assert property (
        @(posedge clk) disable iff (!rst) w_valid && w_ready |-> w_last == (beats == 4'd7)
    );

endmodule

// File: hdl/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_miss_ctrl import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      s2_miss,
    input  index_t    s2_index,
    input  tag_t      s2_tag,
    input  word_sel_t s2_word,
    input  way_t      hit_store_way,
    input  logic      victim_idle,
    output logic      run,
    output logic      recover,
    output index_t    windex,
    output way_t      tag_we,
    output logic      valid_wdata,
    output line_be_t  refill_be [`DC_WAYS],
    output line_t     refill_line,
    output logic      victim_capture,
    output way_t      victim_way,
    output logic      ar_valid,
    output addr_t     ar_addr,
    input  logic      ar_ready,
    input  logic      r_valid,
    input  logic      r_last,
    input  word_t     r_data
);

    cache_state_e state;
    index_t       sweep;
    word_sel_t    refill_cnt;
    word_t        refill_buf [`DC_WORDS];
    plru_t        plru [`DC_SETS];
    way_t         dirty [`DC_SETS];
    plru_t        plru_cur;
    plru_t        plru_next;
    way_t         pick;
    logic         start_miss;

    // tree walk, then point away from the chosen way
    always_comb begin
        plru_cur = plru[s2_index];
        if (!plru_cur[0]) begin
            pick = plru_cur[1] ? 4'b0010 : 4'b0001;
            plru_next = {plru_cur[2], !plru_cur[1], 1'b1};
        end else begin
            pick = plru_cur[2] ? 4'b1000 : 4'b0100;
            plru_next = {!plru_cur[2], plru_cur[1], 1'b0};
        end
    end

    assign start_miss = state == MISS && victim_idle && !ar_valid;
    assign victim_capture = start_miss && |(dirty[s2_index] & victim_way);

    //////////////////////////////////////////////////
    // main FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= INIT;
            sweep <= '0;
            refill_cnt <= '0;
            victim_way <= '0;
            ar_valid <= 1'b0;
        end else begin
            case (state)
                INIT: begin
                    sweep <= sweep + 1'b1;
                    if (sweep == `DC_SETS - 1) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (s2_miss) begin
                        state <= MISS;
                        victim_way <= pick;
                        refill_cnt <= s2_word;
                    end
                end
                MISS: begin
                    if (start_miss) begin
                        ar_valid <= 1'b1;
                    end else if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (r_valid) begin
                        refill_cnt <= refill_cnt + 1'b1;
                        if (r_last) begin
                            state <= FINISH;
                        end
                    end
                end
                FINISH: state <= RECOVER;
                RECOVER: state <= RUN;
                default: state <= INIT;
            endcase
        end
    end

    // wrapped beats land at their own word
    always_ff @(posedge clk) begin
        if (state == REFILL && r_valid) begin
            refill_buf[refill_cnt] <= r_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `DC_SETS; i++) begin
                plru[i] <= '0;
                dirty[i] <= '0;
            end
        end else begin
            if (state == RUN && s2_miss) begin
                plru[s2_index] <= plru_next;
            end
            if (state == FINISH) begin
                dirty[s2_index] <= dirty[s2_index] & ~victim_way;
            end else begin
                dirty[s2_index] <= dirty[s2_index] | hit_store_way;
            end
        end
    end

    //////////////////////////////////////////////////
    // array write port and read channel
    //////////////////////////////////////////////////

    assign run = state == RUN;
    assign recover = state == RECOVER;
    assign windex = (state == INIT) ? sweep : s2_index;
    assign tag_we = (state == INIT) ? '1 : (state == FINISH) ? victim_way : '0;
    assign valid_wdata = state == FINISH;
    assign ar_addr = {s2_tag, s2_index, s2_word, 2'b00};

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            refill_be[w] = {$bits(line_be_t){valid_wdata && victim_way[w]}};
        end
        for (int k = 0; k < `DC_WORDS; k++) begin
            refill_line[k*32 +: 32] = refill_buf[k];
        end
    end

    a_ar_hold: assert property (
        @(posedge clk) disable iff (!rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr)
    );

endmodule

// File: hdl/dcache_lookup.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_lookup import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  logic      wr,
    input  addr_t     addr,
    input  strb_t     wstrb,
    input  word_t     wdata,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     rdata,
    input  logic      run,
    input  logic      recover,
    input  tag_t      way_tag [`DC_WAYS],
    input  logic      way_valid [`DC_WAYS],
    input  line_t     way_line [`DC_WAYS],
    output index_t    rindex,
    output line_be_t  data_be [`DC_WAYS],
    output line_t     line_wdata,
    output logic      s2_miss,
    output index_t    s2_index,
    output tag_t      s2_tag,
    output word_sel_t s2_word,
    output line_t     s2_lines [`DC_WAYS],
    output tag_t      s2_tags [`DC_WAYS],
    output way_t      hit_store_way
);

    logic  accept;
    logic  s2_valid;
    logic  s2_wr;
    strb_t s2_wstrb;
    word_t s2_wdata;
    logic  fwd_valid;
    strb_t fwd_strb;
    word_t fwd_data;
    way_t  hit_way;
    word_t hit_word;

    //////////////////////////////////////////////////
    // stage one, accept and steer the array read
    //////////////////////////////////////////////////

    assign addr_ok = run && (!s2_valid || data_ok);
    assign accept = req && addr_ok;
    assign rindex = accept ? addr[5 +: `DC_INDEX_W] : s2_index;

    always_ff @(posedge clk) begin
        if (!rst) begin
            s2_valid <= 1'b0;
            fwd_valid <= 1'b0;
        end else if (accept) begin
            s2_valid <= 1'b1;
            // store leaving stage two, same word coming in
            fwd_valid <= data_ok && s2_wr && addr[31:2] == {s2_tag, s2_index, s2_word};
        end else begin
            if (data_ok) begin
                s2_valid <= 1'b0;
            end
            if (recover) begin
                fwd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_wr <= wr;
            s2_tag <= addr[31 -: `DC_TAG_W];
            s2_index <= addr[5 +: `DC_INDEX_W];
            s2_word <= addr[2 +: `DC_WORD_SEL_W];
            s2_wstrb <= wstrb;
            s2_wdata <= wdata;
            fwd_strb <= s2_wstrb;
            fwd_data <= s2_wdata;
        end
    end

    //////////////////////////////////////////////////
    // stage two, compare and select
    //////////////////////////////////////////////////

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way[w] = way_valid[w] && way_tag[w] == s2_tag;
            if (hit_way[w]) begin
                hit_word = hit_word | way_line[w][s2_word*32 +: 32];
            end
        end
    end

    assign data_ok = s2_valid && run && |hit_way;
    assign s2_miss = s2_valid && run && !(|hit_way);

    // merge forwarded store bytes
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rdata[b*8 +: 8] = (fwd_valid && fwd_strb[b]) ? fwd_data[b*8 +: 8]
                                                         : hit_word[b*8 +: 8];
        end
    end

    assign hit_store_way = (data_ok && s2_wr) ? hit_way : '0;
    assign line_wdata = {`DC_WORDS{s2_wdata}};

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            data_be[w] = hit_store_way[w] ? line_be_t'(s2_wstrb) << {s2_word, 2'b00} : '0;
        end
    end

    assign s2_lines = way_line;
    assign s2_tags = way_tag;

    // a completed request leaves stage two empty
    a_data_ok_needs_req: assert property (
        @(posedge clk) disable iff (!rst) data_ok && !accept |=> !data_ok
    );

endmodule

// File: hdl/dcache_way_ram.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_way_ram import dcache_pkg::*; (
    input  logic     clk,
    input  index_t   rindex,
    input  index_t   windex,
    input  logic     tag_we,
    input  logic     valid_wdata,
    input  tag_t     tag_wdata,
    input  line_be_t data_be,
    input  line_t    line_wdata,
    output tag_t     tag,
    output logic     valid,
    output line_t    line
);

    tag_t  tag_mem [`DC_SETS];
    logic  valid_mem [`DC_SETS];
    line_t data_mem [`DC_SETS];

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        tag <= tag_mem[rindex];
        valid <= valid_mem[rindex];
        line <= data_mem[rindex];
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[windex] <= tag_wdata;
            valid_mem[windex] <= valid_wdata;
        end
        for (int b = 0; b < `DC_WORDS * 4; b++) begin
            if (data_be[b]) begin
                data_mem[windex][b*8 +: 8] <= line_wdata[b*8 +: 8];
            end
        end
    end

endmodule

// File: hdl/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_WORD_SEL_W-1:0] word_sel_t;
    typedef logic [3:0] strb_t;
    typedef logic [`DC_WORDS*32-1:0] line_t;
    typedef logic [`DC_WORDS*4-1:0] line_be_t;
    typedef logic [`DC_WAYS-1:0] way_t;

    // tree bits, bit 0 is the root
    typedef logic [2:0] plru_t;

    typedef enum logic [2:0] {
        INIT, RUN, MISS, REFILL, FINISH, RECOVER
    } cache_state_e;

    typedef enum logic [2:0] {
        V_IDLE, V_CAPTURE, V_ADDR, V_DATA, V_RESP
    } victim_state_e;

endpackage

// File: include/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////

`define DC_WAYS 4
`define DC_SETS 128

// words per line, also the burst length
`define DC_WORDS 8

//////////////////////////////////////////////////
// address split
//////////////////////////////////////////////////

`define DC_TAG_W 20
`define DC_INDEX_W 7
`define DC_WORD_SEL_W 3

`endif
